// ==== tb.f ====
common/kbd_pkg.sv
hdl/ps2_rx.sv
hdl/scan_ctrl.sv
hdl/key_fifo.sv
hdl/kbd_top.sv
sim/tb_kbd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_kbd -f tb.f \
    && ./obj_dir/Vtb_kbd 2>&1 | tee sim.log \
    || echo "build or run did not complete"
grep -qx "sim passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== sim/tb_kbd.sv ====
// directed testbench for kbd_top, models a PS/2 keyboard and checks the queued key events
`timescale 1ns/100ps

module tb_kbd;

    localparam int          CLK_HALF   = 20;           // 40 ns clk period
    localparam int          KBD_HALF   = 8;            // clk cycles per keyboard clock half period
    localparam int          WAIT_LIMIT = 2000;         // cycles before a wait gives up
    localparam logic [31:0] SEED       = 32'hf4d2_57e0;

    logic                clk;
    logic                arst_n;
    logic                ps2_clk;
    logic                ps2_data;
    logic                rd;
    kbd_pkg::key_event_t event_data;
    logic                ready;
    logic                overflow;
    logic                rx_err;

    kbd_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .rd         (rd),
        .event_data (event_data),
        .ready      (ready),
        .overflow   (overflow),
        .rx_err     (rx_err)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_event(input string name, input kbd_pkg::key_event_t got,
                               input kbd_pkg::key_event_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_code(input string name, input kbd_pkg::scan_code_t got,
                              input kbd_pkg::scan_code_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // expected event: release from F0, extended from E0, code is the byte
    function automatic kbd_pkg::key_event_t make_event(input logic rel, input logic ext,
                                                       input kbd_pkg::scan_code_t code);
        return {rel, ext, code};
    endfunction

    function automatic kbd_pkg::scan_code_t random_code();
        logic [31:0]         rnd;
        kbd_pkg::scan_code_t code;
        code = 8'he0;
        while (code == 8'he0 || code == 8'hf0) begin   // prefixes make no event
            rnd  = $urandom();
            code = rnd[7:0];
        end
        return code;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (ready !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: the event for %s never reached the queue", what);
                stop_on_error();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_rx_err(input string what);
        int n;
        n = 0;
        while (rx_err !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: rx_err never went high after %s", what);
                stop_on_error();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_overflow(input string what);
        int n;
        n = 0;
        while (overflow !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: overflow never went high after %s", what);
                stop_on_error();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // one keyboard bit, data changes while the keyboard clock is high
    task automatic send_bit(input logic b);
        ps2_data = b;
        repeat (KBD_HALF) @(negedge clk);
        ps2_clk = 1'b0;                                // receiver samples on this fall
        repeat (KBD_HALF) @(negedge clk);
        ps2_clk = 1'b1;
    endtask

    task automatic send_frame(input kbd_pkg::scan_code_t code, input logic bad_parity);
        logic par;
        int   i;
        @(negedge clk);
        par = ~^code ^ bad_parity;                     // odd parity, flipped on request
        send_bit(1'b0);                                // start
        for (i = 0; i < 8; i++)
            send_bit(code[i]);                         // lsb first
        send_bit(par);
        send_bit(1'b1);                                // stop
        ps2_data = 1'b1;                               // both lines rest high
        repeat (KBD_HALF) @(negedge clk);
    endtask

    // start bit plus the first data bits, then the keyboard goes quiet
    task automatic send_partial(input kbd_pkg::scan_code_t code, input int nbits);
        int i;
        @(negedge clk);
        send_bit(1'b0);
        for (i = 0; i < nbits - 1; i++)
            send_bit(code[i]);
        ps2_data = 1'b1;
    endtask

    task automatic pop_event();
        rd = 1'b1;                                     // one clk wide strobe
        @(negedge clk);
        rd = 1'b0;
    endtask

    task automatic test_make_code();
        send_frame(8'h1c, 1'b0);
        wait_ready("make code 1C");
        check_event("event_data", event_data, make_event(1'b0, 1'b0, 8'h1c));
        pop_event();
        check_flag("ready", ready, 1'b0);
    endtask

    task automatic test_release();
        send_frame(8'hf0, 1'b0);
        idle_cycles(4);
        check_flag("ready", ready, 1'b0);              // prefix alone queues nothing
        send_frame(8'h1c, 1'b0);
        wait_ready("release of 1C");
        check_event("event_data", event_data, make_event(1'b1, 1'b0, 8'h1c));
        pop_event();
        check_flag("ready", ready, 1'b0);              // exactly one event
    endtask

    task automatic test_extended();
        send_frame(8'he0, 1'b0);
        send_frame(8'h75, 1'b0);
        send_frame(8'he0, 1'b0);
        send_frame(8'hf0, 1'b0);
        send_frame(8'h75, 1'b0);
        wait_ready("extended make of 75");
        check_event("event_data", event_data, make_event(1'b0, 1'b1, 8'h75));
        pop_event();
        wait_ready("extended release of 75");
        check_event("event_data", event_data, make_event(1'b1, 1'b1, 8'h75));
        pop_event();
        check_flag("ready", ready, 1'b0);
    endtask

    task automatic test_frame_error();
        send_frame(8'h1c, 1'b1);
        wait_rx_err("a bad parity frame");
        check_flag("ready", ready, 1'b0);              // bad frame makes no event
        send_frame(8'he0, 1'b0);
        send_frame(8'h33, 1'b1);                       // drops the pending E0
        send_frame(8'h1c, 1'b0);
        wait_ready("code 1C after a frame error");
        check_event("event_data", event_data, make_event(1'b0, 1'b0, 8'h1c));
        check_flag("rx_err", rx_err, 1'b1);
        pop_event();
        check_flag("rx_err", rx_err, 1'b0);            // rd clears it
        check_flag("ready", ready, 1'b0);
    endtask

    task automatic test_queue_overflow();
        kbd_pkg::scan_code_t codes [4];
        kbd_pkg::scan_code_t extra;
        int                  i;
        for (i = 0; i < 4; i++) begin
            codes[i] = random_code();
            send_frame(codes[i], 1'b0);
        end
        wait_ready("the first random code");
        check_flag("overflow", overflow, 1'b0);        // four fit exactly
        extra = random_code();
        send_frame(extra, 1'b0);
        wait_overflow("a fifth code into a full queue");
        for (i = 0; i < 4; i++) begin
            check_code("event_data[7:0]", event_data[7:0], codes[i]);
            check_event("event_data", event_data, make_event(1'b0, 1'b0, codes[i]));
            pop_event();
        end
        check_flag("ready", ready, 1'b0);              // fifth was dropped
    endtask

    task automatic test_idle_recovery();
        send_partial(8'h55, 5);
        idle_cycles(2500);                             // longer than the receiver timeout
        check_flag("ready", ready, 1'b0);
        send_frame(8'h2a, 1'b0);
        wait_ready("code 2A after idle recovery");
        check_code("event_data[7:0]", event_data[7:0], 8'h2a);
        check_event("event_data", event_data, make_event(1'b0, 1'b0, 8'h2a));
        pop_event();
        check_flag("ready", ready, 1'b0);
    endtask

    initial begin
        arst_n   = 1'b0;
        ps2_clk  = 1'b1;                               // keyboard idle
        ps2_data = 1'b1;
        rd       = 1'b0;
        void'($urandom(SEED));
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("ready", ready, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        check_flag("rx_err", rx_err, 1'b0);
        test_make_code();
        test_release();
        test_extended();
        test_frame_error();
        test_queue_overflow();
        test_idle_recovery();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== hdl/kbd_top.sv ====
// keyboard receive subsystem top: sets parameters and wires receiver, control FSM and event queue
`timescale 1ns/100ps

module kbd_top #(
    parameter int IDLE_CYCLES = 2000,              // receiver idle timeout, clk cycles
    parameter int DEPTH_LOG2  = 2                  // queue holds 2**DEPTH_LOG2 events
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ps2_clk,           // from keyboard
    input  logic                ps2_data,          // from keyboard
    input  logic                rd,                // processor pop strobe
    output kbd_pkg::key_event_t event_data,        // head of queue
    output logic                ready,             // queue not empty
    output logic                overflow,          // sticky, event dropped
    output logic                rx_err             // bad frame seen, cleared by rd
);

    kbd_pkg::scan_code_t rx_byte;
    logic                rx_valid;
    logic                rx_frame_err;
    kbd_pkg::key_event_t ev_data;
    logic                ev_valid;

    ps2_rx #(
        .IDLE_CYCLES (IDLE_CYCLES)
    ) u_rx (
        .clk          (clk),
        .arst_n       (arst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    scan_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .rd           (rd),
        .ev_data      (ev_data),
        .ev_valid     (ev_valid),
        .rx_err       (rx_err)
    );

    key_fifo #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (ev_valid),
        .wr_data  (ev_data),
        .rd       (rd),
        .rd_data  (event_data),
        .ready    (ready),
        .overflow (overflow)
    );

endmodule

// ==== hdl/key_fifo.sv ====
// show-ahead key event queue: push strobe from control, pop strobe from processor, sticky overflow
`timescale 1ns/100ps

module key_fifo #(
    parameter int DEPTH_LOG2 = 2                   // log2 of entries
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wr,                // push strobe
    input  kbd_pkg::key_event_t wr_data,
    input  logic                rd,                // pop strobe, ignored when empty
    output kbd_pkg::key_event_t rd_data,           // head entry
    output logic                ready,             // not empty
    output logic                overflow           // sticky, event dropped
);

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam logic [DEPTH_LOG2:0] DEPTH_CNT = (DEPTH_LOG2 + 1)'(DEPTH);

    kbd_pkg::key_event_t   mem [DEPTH];            // storage, no reset
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;                  // occupancy, 0..DEPTH
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == DEPTH_CNT);
    assign ready   = (count != '0);
    assign do_pop  = rd && ready;
    assign do_push = wr && (!full || do_pop);      // a pop frees the slot this cycle

    assign rd_data = mem[rd_ptr];                  // show-ahead

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;               // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;               // both or neither
            endcase
            if (wr && !do_push)
                overflow <= 1'b1;                      // only reset clears it
        end
    end

    a_count_max : assert property (
        @(posedge clk) disable iff (!arst_n) count <= DEPTH_CNT
    );

    // an underflow would wrap the count to all ones
    a_count_no_underflow : assert property (
        @(posedge clk) disable iff (!arst_n) (count == '0) |=> (count <= 1)
    );

endmodule

// ==== hdl/scan_ctrl.sv ====
// scan-code control FSM: folds E0/F0 prefixes into key events and keeps the sticky frame error flag
`timescale 1ns/100ps

module scan_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  kbd_pkg::scan_code_t rx_byte,           // byte from receiver
    input  logic                rx_valid,          // byte strobe
    input  logic                rx_frame_err,      // bad frame strobe
    input  logic                rd,                // processor pop, also clears rx_err
    output kbd_pkg::key_event_t ev_data,           // event to queue
    output logic                ev_valid,          // event strobe
    output logic                rx_err             // sticky frame error
);

    kbd_pkg::ctrl_state_t state;
    kbd_pkg::ctrl_state_t state_nxt;
    kbd_pkg::key_event_t  ev_nxt;
    logic                 is_pfx;                  // byte is E0 or F0
    logic                 rel_flag;                // F0 pending
    logic                 ext_flag;                // E0 pending

    assign is_pfx = (rx_byte == kbd_pkg::PFX_EXT) || (rx_byte == kbd_pkg::PFX_BRK);

    assign rel_flag = (state == kbd_pkg::ST_BRK) || (state == kbd_pkg::ST_EXT_BRK);
    assign ext_flag = (state == kbd_pkg::ST_EXT) || (state == kbd_pkg::ST_EXT_BRK);

    // event word from current prefix state
    always_comb begin
        ev_nxt                      = '0;
        ev_nxt[7:0]                 = rx_byte;
        ev_nxt[kbd_pkg::EV_REL_BIT] = rel_flag;
        ev_nxt[kbd_pkg::EV_EXT_BIT] = ext_flag;
    end

    // next state
    always_comb begin
        state_nxt = state;
        if (rx_frame_err) begin
            state_nxt = kbd_pkg::ST_IDLE;              // error drops any prefix
        end else if (rx_valid) begin
            if (rx_byte == kbd_pkg::PFX_EXT) begin
                state_nxt = kbd_pkg::ST_EXT;           // E0 always opens an extended key
            end else if (rx_byte == kbd_pkg::PFX_BRK) begin
                case (state)
                    kbd_pkg::ST_EXT,
                    kbd_pkg::ST_EXT_BRK: state_nxt = kbd_pkg::ST_EXT_BRK;
                    default:             state_nxt = kbd_pkg::ST_BRK;
                endcase
            end else begin
                state_nxt = kbd_pkg::ST_IDLE;          // code consumes the prefixes
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= kbd_pkg::ST_IDLE;
            ev_valid <= 1'b0;
            rx_err   <= 1'b0;
        end else begin
            state    <= state_nxt;
            ev_valid <= rx_valid && !is_pfx;           // prefixes make no event
            if (rx_frame_err)
                rx_err <= 1'b1;                        // set wins over a same-cycle rd
            else if (rd)
                rx_err <= 1'b0;
        end
    end

    // payload, loaded with the strobe
    always_ff @(posedge clk) begin
        if (rx_valid && !is_pfx)
            ev_data <= ev_nxt;
    end

    a_ev_after_rx : assert property (
        @(posedge clk) disable iff (!arst_n) ev_valid |-> $past(rx_valid)
    );

endmodule

// ==== hdl/ps2_rx.sv ====
// PS/2 frame receiver: syncs keyboard clock and data, checks each 11-bit frame, strobes bytes or errors
`timescale 1ns/100ps

module ps2_rx #(
    parameter int IDLE_CYCLES = 2000               // clk cycles without edge before frame is dropped
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ps2_clk,            // raw keyboard clock, async
    input  logic               ps2_data,           // raw keyboard data, async
    output kbd_pkg::scan_code_t rx_byte,           // last good byte
    output logic               rx_valid,           // one-cycle strobe, good byte
    output logic               rx_frame_err        // one-cycle strobe, bad start/stop/parity
);

    localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);
    localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(IDLE_CYCLES - 1);

    logic [2:0]        clk_sync;                   // keyboard clock synchronizer + edge history
    logic [1:0]        data_sync;                  // keyboard data synchronizer
    logic              fall;                       // falling edge of keyboard clock
    logic              data_s;                     // synced data bit
    logic [3:0]        bit_cnt;                    // samples taken in current frame
    logic [9:0]        buffer;                     // start, 8 data, parity
    logic [IDLE_W-1:0] idle_cnt;                   // cycles since last edge
    logic              idle_expire;                // partial frame timed out
    logic              start_ok;
    logic              stop_ok;
    logic              parity_ok;

    // lines idle high, so reset to ones to avoid a false edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};     // shift in raw clock
            data_sync <= {data_sync[0], ps2_data};     // two flops for data
        end
    end

    assign fall   = clk_sync[2] & ~clk_sync[1];        // was high, now low
    assign data_s = data_sync[1];

    // frame checks, valid at the 11th sample
    assign start_ok  = (buffer[0] == 1'b0);            // start bit low
    assign stop_ok   = data_s;                         // stop bit is the current sample
    assign parity_ok = ^buffer[9:1];                   // odd over data + parity

    assign idle_expire = (bit_cnt != 4'd0) && (idle_cnt == IDLE_LAST);

    // bit counter, shift buffer and result strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt      <= 4'd0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;                      // strobes default low
            rx_frame_err <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin            // stop bit sample
                    if (start_ok && stop_ok && parity_ok)
                        rx_valid <= 1'b1;
                    else
                        rx_frame_err <= 1'b1;
                    bit_cnt <= 4'd0;                   // ready for next frame
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (idle_expire) begin
                bit_cnt <= 4'd0;                       // drop half frame
            end
        end
    end

    // shift lsb first, first sample ends up in buffer[0]
    always_ff @(posedge clk) begin
        if (fall && (bit_cnt != 4'd10))
            buffer <= {data_s, buffer[9:1]};
    end

    // byte register, payload only
    always_ff @(posedge clk) begin
        if (fall && (bit_cnt == 4'd10) && start_ok && stop_ok && parity_ok)
            rx_byte <= buffer[8:1];
    end

    // idle watchdog, only counts inside a frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idle_cnt <= '0;
        end else if (fall || (bit_cnt == 4'd0) || idle_expire) begin
            idle_cnt <= '0;                            // restart on edge or between frames
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    a_bit_cnt_range : assert property (
        @(posedge clk) disable iff (!arst_n) bit_cnt <= 4'd10
    );

    a_strobes_exclusive : assert property (
        @(posedge clk) disable iff (!arst_n) !(rx_valid && rx_frame_err)
    );

endmodule

// ==== common/kbd_pkg.sv ====
// shared scan-code and key-event types, prefix codes and control states for the keyboard subsystem
package kbd_pkg;

    // one raw byte as it arrives from the keyboard, set 2 code
    typedef logic [7:0] scan_code_t;

    // key event as queued for the processor
    //   bit 9    release flag (F0 seen before the code)
    //   bit 8    extended flag (E0 seen before the code)
    //   bit 7:0  scan code itself
    typedef logic [9:0] key_event_t;

    localparam int EV_REL_BIT = 9;                 // release flag position
    localparam int EV_EXT_BIT = 8;                 // extended flag position

    localparam scan_code_t PFX_EXT = 8'he0;        // extended key prefix
    localparam scan_code_t PFX_BRK = 8'hf0;        // break (release) prefix

    // prefix tracking in scan_ctrl
    typedef enum logic [1:0] {
        ST_IDLE,                                   // no prefix pending
        ST_EXT,                                    // E0 seen
        ST_BRK,                                    // F0 seen
        ST_EXT_BRK                                 // E0 then F0 seen
    } ctrl_state_t;

endpackage
